//--- vlog.f
+incdir+include
source/frontend_pkg.sv
source/riscv_isa_pkg.sv
source/pc_gen.sv
source/instr_scan.sv
source/ras.sv
source/branch_predict.sv
source/fetch_queue.sv
source/frontend_top.sv
verification/tb_frontend.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, simulate, then judge the run from its log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_frontend -f vlog.f &&
    ./obj_dir/Vtb_frontend 2>&1 | tee sim.log &&
    grep -q "Test completed successfully" sim.log &&
    ! grep -q "Test failed" sim.log ||
    { echo "simulation did not pass, see sim.log"; exit 1; }
echo "simulation passed"

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ------------------------------
// memory image
// ------------------------------
// address in the upper half of each row, instruction word in the lower half
localparam int IMAGE_SIZE = 9;
logic [63:0] imem_image [IMAGE_SIZE] = '{
    // bne a0, a1, +8 then blt a0, a1, -8
    64'h0000_0104_00b5_1463,
    64'h0000_010c_feb5_4ce3,
    // jal ra, +0x40 then jalr x0, 0(a2)
    64'h0000_0200_0400_00ef,
    64'h0000_0204_0006_0067,
    // ret
    64'h0000_0244_0000_8067,
    // loop body, jal ra, +0x20 / bne +8 / blt -12
    64'h0000_0604_0200_00ef,
    64'h0000_0608_00b5_1463,
    64'h0000_060c_feb5_4ae3,
    // subroutine is a single ret
    64'h0000_0624_0000_8067
};

// ------------------------------
// expected entries
// ------------------------------
typedef struct packed {
    logic [31:0] addr;
    cf_e         cf;
    logic [31:0] target;
} exp_entry_t;

localparam int EXP_COUNT = 38;
exp_entry_t exp_table [EXP_COUNT] = '{
    // boot, straight line
    '{32'h0000_0080, NO_CF, 32'h0000_0084},
    '{32'h0000_0084, NO_CF, 32'h0000_0088},
    '{32'h0000_0088, NO_CF, 32'h0000_008c},
    '{32'h0000_008c, NO_CF, 32'h0000_0090},
    // forward branch falls through, backward branch loops to 0x104
    '{32'h0000_0100, NO_CF, 32'h0000_0104},
    '{32'h0000_0104, NO_CF, 32'h0000_0108},
    '{32'h0000_0108, NO_CF, 32'h0000_010c},
    '{32'h0000_010c, BRANCH, 32'h0000_0104},
    '{32'h0000_0104, NO_CF, 32'h0000_0108},
    '{32'h0000_0108, NO_CF, 32'h0000_010c},
    '{32'h0000_010c, BRANCH, 32'h0000_0104},
    '{32'h0000_0104, NO_CF, 32'h0000_0108},
    // call, return to call + 4, then an unpredicted jalr
    '{32'h0000_0200, JUMP, 32'h0000_0240},
    '{32'h0000_0240, NO_CF, 32'h0000_0244},
    '{32'h0000_0244, RETURN, 32'h0000_0204},
    '{32'h0000_0204, JUMP_R, 32'h0000_0208},
    '{32'h0000_0208, NO_CF, 32'h0000_020c},
    // trap vector wins over mispredict
    '{32'h0000_0400, NO_CF, 32'h0000_0404},
    '{32'h0000_0404, NO_CF, 32'h0000_0408},
    '{32'h0000_0408, NO_CF, 32'h0000_040c},
    // commit wins over exception, restart at commit + 4
    '{32'h0000_0504, NO_CF, 32'h0000_0508},
    '{32'h0000_0508, NO_CF, 32'h0000_050c},
    '{32'h0000_050c, NO_CF, 32'h0000_0510},
    // debug wins over everything
    '{32'h0000_0800, NO_CF, 32'h0000_0804},
    '{32'h0000_0804, NO_CF, 32'h0000_0808},
    '{32'h0000_0808, NO_CF, 32'h0000_080c},
    // loop with a call, two full turns and a bit
    '{32'h0000_0600, NO_CF, 32'h0000_0604},
    '{32'h0000_0604, JUMP, 32'h0000_0624},
    '{32'h0000_0624, RETURN, 32'h0000_0608},
    '{32'h0000_0608, NO_CF, 32'h0000_060c},
    '{32'h0000_060c, BRANCH, 32'h0000_0600},
    '{32'h0000_0600, NO_CF, 32'h0000_0604},
    '{32'h0000_0604, JUMP, 32'h0000_0624},
    '{32'h0000_0624, RETURN, 32'h0000_0608},
    '{32'h0000_0608, NO_CF, 32'h0000_060c},
    '{32'h0000_060c, BRANCH, 32'h0000_0600},
    '{32'h0000_0600, NO_CF, 32'h0000_0604},
    '{32'h0000_0604, JUMP, 32'h0000_0624}
};

`endif

//--- verification/tb_frontend.sv
`timescale 1ns/1ns

module tb_frontend;
    import frontend_pkg::*;

    logic        clk_i;
    logic        rst_ni;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    logic        imem_valid_i;
    logic [31:0] imem_data_i;
    logic        resolve_mispredict_i;
    logic [31:0] resolve_target_i;
    logic        eret_i;
    logic [31:0] epc_i;
    logic        ex_valid_i;
    logic [31:0] trap_vector_i;
    logic        set_pc_commit_i;
    logic [31:0] pc_commit_i;
    logic        set_debug_pc_i;
    logic        entry_valid_o;
    logic        entry_ready_i;
    logic [31:0] entry_addr_o;
    logic [31:0] entry_instr_o;
    cf_e         entry_cf_o;
    logic [31:0] entry_target_o;

    `include "tb_program.svh"

    // ------------------------------
    // step table
    // ------------------------------
    // strobes are debug, commit, exception, eret, mispredict from msb down
    typedef struct packed {
        logic [4:0]  strobes;
        logic        rand_ready;
        logic [31:0] mis_target;
        logic [31:0] epc;
        logic [31:0] trap;
        logic [31:0] commit;
        int          count;
    } step_t;

    localparam int STEP_COUNT   = 7;
    localparam int STEP_TIMEOUT = 400;
    step_t steps [STEP_COUNT] = '{
        '{5'b00000, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 4},
        '{5'b00001, 1'b0, 32'h0000_0100, 32'h0, 32'h0, 32'h0, 8},
        '{5'b00010, 1'b0, 32'h0, 32'h0000_0200, 32'h0, 32'h0, 5},
        '{5'b00101, 1'b0, 32'h0000_0300, 32'h0, 32'h0000_0400, 32'h0, 3},
        '{5'b01100, 1'b0, 32'h0, 32'h0, 32'h0000_0400, 32'h0000_0500, 3},
        '{5'b11001, 1'b0, 32'h0000_0300, 32'h0, 32'h0, 32'h0000_0500, 3},
        '{5'b00001, 1'b1, 32'h0000_0600, 32'h0, 32'h0, 32'h0, 12}
    };
    string step_name [STEP_COUNT] = '{"boot", "branch", "call and return",
        "exception over mispredict", "commit over exception", "debug over all",
        "random ready"};

    int          seed = 37;
    int          errors = 0;
    int          checks = 0;
    int          failed_tests = 0;
    int          next_entry = 0;
    logic        mem_req;
    logic [31:0] mem_addr;

    frontend_top frontend_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // image word where present and otherwise an addi to x0 that folds the address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [11:0] imm;
        imm = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
        word_at = {imm, 5'd0, 3'd0, 5'd0, 7'h13};
        for (int i = 0; i < IMAGE_SIZE; i++) begin
            if (imem_image[i][63:32] == addr) begin
                word_at = imem_image[i][31:0];
            end
        end
    endfunction

    // ------------------------------
    // memory model
    // ------------------------------
    // requests are sampled mid-cycle and answered in the next cycle
    initial begin
        imem_valid_i = 1'b0;
        imem_data_i  = 32'h0;
        forever begin
            @(negedge clk_i);
            mem_req  = imem_req_o;
            mem_addr = imem_addr_o;
            @(posedge clk_i);
            #10;
            imem_valid_i = mem_req;
            imem_data_i  = mem_req ? word_at(mem_addr) : 32'h0;
        end
    end

    task automatic run_step(input int s);
        step_t      st;
        exp_entry_t e;
        int         got;
        int         cycles;
        int         step_err;
        int         rnd;
        st       = steps[s];
        got      = 0;
        cycles   = 0;
        step_err = errors;
        // one redirect cycle with the backend stalled
        if (st.strobes != 5'b0) begin
            set_debug_pc_i       = st.strobes[4];
            set_pc_commit_i      = st.strobes[3];
            ex_valid_i           = st.strobes[2];
            eret_i               = st.strobes[1];
            resolve_mispredict_i = st.strobes[0];
            resolve_target_i     = st.mis_target;
            epc_i                = st.epc;
            trap_vector_i        = st.trap;
            pc_commit_i          = st.commit;
            entry_ready_i        = 1'b0;
            @(posedge clk_i);
            #10;
            set_debug_pc_i       = 1'b0;
            set_pc_commit_i      = 1'b0;
            ex_valid_i           = 1'b0;
            eret_i               = 1'b0;
            resolve_mispredict_i = 1'b0;
        end
        while (got < st.count && cycles < STEP_TIMEOUT) begin
            if (st.rand_ready) begin
                // accept about one cycle in four so the queue fills up
                rnd = $random(seed);
                entry_ready_i = (rnd[1:0] == 2'b00);
            end else begin
                entry_ready_i = 1'b1;
            end
            @(negedge clk_i);
            if (entry_valid_o && entry_ready_i) begin
                e = exp_table[next_entry];
                checks++;
                if (entry_addr_o !== e.addr) begin
                    $display("ERR %0t entry_addr_o expected %h got %h", $time, e.addr,
                             entry_addr_o);
                    errors++;
                end
                if (entry_instr_o !== word_at(e.addr)) begin
                    $display("ERR %0t entry_instr_o expected %h got %h", $time,
                             word_at(e.addr), entry_instr_o);
                    errors++;
                end
                if (entry_cf_o !== e.cf) begin
                    $display("ERR %0t entry_cf_o expected %0d got %0d", $time, e.cf,
                             entry_cf_o);
                    errors++;
                end
                if (entry_target_o !== e.target) begin
                    $display("ERR %0t entry_target_o expected %h got %h", $time, e.target,
                             entry_target_o);
                    errors++;
                end
                got++;
                next_entry++;
            end
            @(posedge clk_i);
            #10;
            cycles++;
        end
        entry_ready_i = 1'b0;
        if (got < st.count) begin
            $display("timeout in %s, only %0d of %0d entries arrived", step_name[s], got,
                     st.count);
            errors++;
            next_entry += st.count - got;
        end
        step_err = errors - step_err;
        if (step_err != 0) begin
            failed_tests++;
        end
        $display("test %s: %0d entries, %0d errors", step_name[s], got, step_err);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_ni               = 1'b0;
        entry_ready_i        = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i     = 32'h0;
        eret_i               = 1'b0;
        epc_i                = 32'h0;
        ex_valid_i           = 1'b0;
        trap_vector_i        = 32'h0;
        set_pc_commit_i      = 1'b0;
        pc_commit_i          = 32'h0;
        set_debug_pc_i       = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_i);
            #10;
            if (imem_req_o !== 1'b0) begin
                $display("ERR %0t imem_req_o expected 0 got %b", $time, imem_req_o);
                errors++;
            end
            if (entry_valid_o !== 1'b0) begin
                $display("ERR %0t entry_valid_o expected 0 got %b", $time, entry_valid_o);
                errors++;
            end
        end
        rst_ni = 1'b1;
        // the boot fetch goes out in the first cycle after reset release
        @(posedge clk_i);
        #10;
        if (imem_req_o !== 1'b1) begin
            $display("ERR %0t imem_req_o expected 1 got %b", $time, imem_req_o);
            errors++;
        end
        if (imem_addr_o !== BOOT_ADDR) begin
            $display("ERR %0t imem_addr_o expected %h got %h", $time, BOOT_ADDR,
                     imem_addr_o);
            errors++;
        end
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test reset: %0d errors", errors);
        for (int s = 0; s < STEP_COUNT; s++) begin
            run_step(s);
        end
        $display("%0d tests, %0d failed, %0d entries checked, %0d errors", STEP_COUNT + 1,
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/frontend_top.sv
`timescale 1ns/1ns

module frontend_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // instruction memory, one-cycle response
    output logic                           imem_req_o,
    output logic [frontend_pkg::VLEN-1:0]  imem_addr_o,
    input  logic                           imem_valid_i,
    input  logic [riscv_isa_pkg::ILEN-1:0] imem_data_i,
    // backend redirects
    input  logic                           resolve_mispredict_i,
    input  logic [frontend_pkg::VLEN-1:0]  resolve_target_i,
    input  logic                           eret_i,
    input  logic [frontend_pkg::VLEN-1:0]  epc_i,
    input  logic                           ex_valid_i,
    input  logic [frontend_pkg::VLEN-1:0]  trap_vector_i,
    input  logic                           set_pc_commit_i,
    input  logic [frontend_pkg::VLEN-1:0]  pc_commit_i,
    input  logic                           set_debug_pc_i,
    // fetch entries to the backend
    output logic                           entry_valid_o,
    input  logic                           entry_ready_i,
    output logic [frontend_pkg::VLEN-1:0]  entry_addr_o,
    output logic [riscv_isa_pkg::ILEN-1:0] entry_instr_o,
    output frontend_pkg::cf_e              entry_cf_o,
    output logic [frontend_pkg::VLEN-1:0]  entry_target_o
);
    import frontend_pkg::*;

    logic              resp_valid;
    logic [VLEN-1:0]   resp_addr;
    logic              predict_valid;
    logic [VLEN-1:0]   predict_target;
    cf_e               bp_cf;
    logic [VLEN-1:0]   bp_target;
    logic              redirect;
    logic [QCNT_W-1:0] free_slots;

    // ------------------------------
    // next PC and fetch request
    // ------------------------------
    pc_gen pc_gen_i (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .set_debug_pc_i       (set_debug_pc_i),
        .set_pc_commit_i      (set_pc_commit_i),
        .pc_commit_i          (pc_commit_i),
        .ex_valid_i           (ex_valid_i),
        .trap_vector_i        (trap_vector_i),
        .eret_i               (eret_i),
        .epc_i                (epc_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_target_i     (resolve_target_i),
        .imem_valid_i         (imem_valid_i),
        .predict_valid_i      (predict_valid),
        .predict_target_i     (predict_target),
        .free_slots_i         (free_slots),
        .imem_req_o           (imem_req_o),
        .imem_addr_o          (imem_addr_o),
        .resp_valid_o         (resp_valid),
        .resp_addr_o          (resp_addr),
        .redirect_o           (redirect)
    );

    // scan and predict straight off the memory data
    branch_predict branch_predict_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .resp_valid_i     (resp_valid),
        .resp_addr_i      (resp_addr),
        .resp_instr_i     (imem_data_i),
        .predict_valid_o  (predict_valid),
        .predict_target_o (predict_target),
        .cf_o             (bp_cf),
        .target_o         (bp_target)
    );

    // a redirect empties the queue
    fetch_queue fetch_queue_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (redirect),
        .wr_valid_i     (resp_valid),
        .wr_addr_i      (resp_addr),
        .wr_instr_i     (imem_data_i),
        .wr_cf_i        (bp_cf),
        .wr_target_i    (bp_target),
        .entry_valid_o  (entry_valid_o),
        .entry_ready_i  (entry_ready_i),
        .entry_addr_o   (entry_addr_o),
        .entry_instr_o  (entry_instr_o),
        .entry_cf_o     (entry_cf_o),
        .entry_target_o (entry_target_o),
        .free_slots_o   (free_slots)
    );

endmodule

//--- source/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    // write side takes at most one response per cycle
    input  logic                              wr_valid_i,
    input  logic [frontend_pkg::VLEN-1:0]     wr_addr_i,
    input  logic [riscv_isa_pkg::ILEN-1:0]    wr_instr_i,
    input  frontend_pkg::cf_e                 wr_cf_i,
    input  logic [frontend_pkg::VLEN-1:0]     wr_target_i,
    // backend side
    output logic                              entry_valid_o,
    input  logic                              entry_ready_i,
    output logic [frontend_pkg::VLEN-1:0]     entry_addr_o,
    output logic [riscv_isa_pkg::ILEN-1:0]    entry_instr_o,
    output frontend_pkg::cf_e                 entry_cf_o,
    output logic [frontend_pkg::VLEN-1:0]     entry_target_o,
    output logic [frontend_pkg::QCNT_W-1:0]   free_slots_o
);
    import frontend_pkg::*;
    import riscv_isa_pkg::*;

    // entry storage
    logic [VLEN-1:0]   addr_q   [QUEUE_DEPTH];
    logic [ILEN-1:0]   instr_q  [QUEUE_DEPTH];
    cf_e               cf_q     [QUEUE_DEPTH];
    logic [VLEN-1:0]   target_q [QUEUE_DEPTH];

    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QCNT_W-1:0] count_q;
    logic              push;
    logic              pop;

    // pc_gen only requests while a slot is free
    assign push = wr_valid_i;
    assign pop  = entry_valid_o & entry_ready_i;

    assign entry_valid_o  = (count_q != '0);
    assign entry_addr_o   = addr_q[rd_ptr_q];
    assign entry_instr_o  = instr_q[rd_ptr_q];
    assign entry_cf_o     = cf_q[rd_ptr_q];
    assign entry_target_o = target_q[rd_ptr_q];
    assign free_slots_o   = QCNT_W'(QUEUE_DEPTH) - count_q;

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush wins over a write in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + QPTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + QPTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + QCNT_W'(1);
                2'b01:   count_q <= count_q - QCNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // payload write
    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[wr_ptr_q]   <= wr_addr_i;
            instr_q[wr_ptr_q]  <= wr_instr_i;
            cf_q[wr_ptr_q]     <= wr_cf_i;
            target_q[wr_ptr_q] <= wr_target_i;
        end
    end

endmodule

//--- source/branch_predict.sv
`timescale 1ns/1ns

module branch_predict (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          resp_valid_i,
    input  logic [frontend_pkg::VLEN-1:0] resp_addr_i,
    input  riscv_isa_pkg::instr_u         resp_instr_i,
    output logic                          predict_valid_o,
    output logic [frontend_pkg::VLEN-1:0] predict_target_o,
    output frontend_pkg::cf_e             cf_o,
    output logic [frontend_pkg::VLEN-1:0] target_o
);
    import frontend_pkg::*;

    cf_e             scan_cf;
    logic            scan_call;
    logic            scan_return;
    logic [VLEN-1:0] scan_imm;
    logic [VLEN-1:0] seq_addr;
    logic            taken;
    logic            push;
    logic            pop;
    logic [VLEN-1:0] push_addr;
    logic [VLEN-1:0] ras_top;
    logic            ras_valid;

    instr_scan instr_scan_i (
        .instr_i     (resp_instr_i),
        .cf_o        (scan_cf),
        .is_call_o   (scan_call),
        .is_return_o (scan_return),
        .imm_o       (scan_imm)
    );

    assign seq_addr = resp_addr_i + VLEN'(4);

    // ------------------------------
    // taken decision and target
    // ------------------------------
    always_comb begin
        taken    = 1'b0;
        target_o = seq_addr;
        cf_o     = NO_CF;
        case (scan_cf)
            // static rule, backward taken and forward not taken
            BRANCH: begin
                if (scan_imm[VLEN-1]) begin
                    taken    = 1'b1;
                    cf_o     = BRANCH;
                    target_o = resp_addr_i + scan_imm;
                end
            end
            JUMP: begin
                taken    = 1'b1;
                cf_o     = JUMP;
                target_o = resp_addr_i + scan_imm;
            end
            // flagged for the backend but fetch runs on sequentially
            JUMP_R: cf_o = JUMP_R;
            RETURN: begin
                cf_o = RETURN;
                // an empty stack leaves the return unpredicted
                if (ras_valid) begin
                    taken    = 1'b1;
                    target_o = ras_top;
                end
            end
            default: cf_o = NO_CF;
        endcase
    end

    assign predict_valid_o  = resp_valid_i & taken;
    assign predict_target_o = target_o;

    // calls save the link address, predicted returns consume it
    assign push      = resp_valid_i & scan_call;
    assign pop       = resp_valid_i & scan_return & ras_valid;
    assign push_addr = seq_addr;

    ras ras_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (push),
        .pop_i   (pop),
        .data_i  (push_addr),
        .top_o   (ras_top),
        .valid_o (ras_valid)
    );

endmodule

//--- source/ras.sv
`timescale 1ns/1ns

module ras (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          push_i,
    input  logic                          pop_i,
    input  logic [frontend_pkg::VLEN-1:0] data_i,
    output logic [frontend_pkg::VLEN-1:0] top_o,
    output logic                          valid_o
);
    import frontend_pkg::*;

    // index 0 is the top of the stack
    logic [VLEN-1:0]      addr_q [RAS_DEPTH];
    logic [RAS_DEPTH-1:0] valid_q;

    assign top_o   = addr_q[0];
    assign valid_o = valid_q[0];

    // ------------------------------
    // valid bits
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (push_i && pop_i) begin
            // replace the top in place
            valid_q[0] <= 1'b1;
        end else if (push_i) begin
            // the oldest entry falls off the bottom on overflow
            valid_q <= {valid_q[RAS_DEPTH-2:0], 1'b1};
        end else if (pop_i) begin
            valid_q <= {1'b0, valid_q[RAS_DEPTH-1:1]};
        end
    end

    // return addresses shift along with their valid bits
    always_ff @(posedge clk_i) begin
        if (push_i && pop_i) begin
            addr_q[0] <= data_i;
        end else if (push_i) begin
            for (int i = RAS_DEPTH - 1; i > 0; i--) begin
                addr_q[i] <= addr_q[i-1];
            end
            addr_q[0] <= data_i;
        end else if (pop_i) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                addr_q[i] <= addr_q[i+1];
            end
        end
    end

endmodule

//--- source/instr_scan.sv
`timescale 1ns/1ns

module instr_scan (
    input  riscv_isa_pkg::instr_u         instr_i,
    output frontend_pkg::cf_e             cf_o,
    output logic                          is_call_o,
    output logic                          is_return_o,
    output logic [frontend_pkg::VLEN-1:0] imm_o
);
    import frontend_pkg::*;
    import riscv_isa_pkg::*;

    logic jal_rd_link;
    logic jalr_rd_link;
    logic jalr_rs1_link;
    logic jalr_rd_zero;

    // ra and t0 both count as link registers
    assign jal_rd_link   = (instr_i.j_fmt.rd == REG_RA) || (instr_i.j_fmt.rd == REG_T0);
    assign jalr_rd_link  = (instr_i.i_fmt.rd == REG_RA) || (instr_i.i_fmt.rd == REG_T0);
    assign jalr_rs1_link = (instr_i.i_fmt.rs1 == REG_RA) || (instr_i.i_fmt.rs1 == REG_T0);
    assign jalr_rd_zero  = (instr_i.i_fmt.rd == 5'd0);

    always_comb begin
        cf_o        = NO_CF;
        is_call_o   = 1'b0;
        is_return_o = 1'b0;
        imm_o       = '0;
        case (instr_i.i_fmt.opcode)
            // ------------------------------
            // conditional branch
            // ------------------------------
            OPC_BRANCH: begin
                cf_o  = BRANCH;
                // sign bit in imm12, bit 0 always zero
                imm_o = {{(VLEN - 12){instr_i.b_fmt.imm12}},
                         instr_i.b_fmt.imm11,
                         instr_i.b_fmt.imm10_5,
                         instr_i.b_fmt.imm4_1,
                         1'b0};
            end
            // ------------------------------
            // direct jump
            // ------------------------------
            OPC_JAL: begin
                cf_o      = JUMP;
                is_call_o = jal_rd_link;
                imm_o     = {{(VLEN - 20){instr_i.j_fmt.imm20}},
                             instr_i.j_fmt.imm19_12,
                             instr_i.j_fmt.imm11,
                             instr_i.j_fmt.imm10_1,
                             1'b0};
            end
            // register jump, target comes from a register
            OPC_JALR: begin
                is_return_o = jalr_rs1_link & jalr_rd_zero;
                is_call_o   = jalr_rd_link;
                // returns go to the stack, everything else stays unpredicted
                cf_o        = (jalr_rs1_link && jalr_rd_zero) ? RETURN : JUMP_R;
            end
            default: begin
                cf_o = NO_CF;
            end
        endcase
    end

endmodule

//--- source/pc_gen.sv
`timescale 1ns/1ns

module pc_gen (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // backend redirects, highest priority first
    input  logic                            set_debug_pc_i,
    input  logic                            set_pc_commit_i,
    input  logic [frontend_pkg::VLEN-1:0]   pc_commit_i,
    input  logic                            ex_valid_i,
    input  logic [frontend_pkg::VLEN-1:0]   trap_vector_i,
    input  logic                            eret_i,
    input  logic [frontend_pkg::VLEN-1:0]   epc_i,
    input  logic                            resolve_mispredict_i,
    input  logic [frontend_pkg::VLEN-1:0]   resolve_target_i,
    // memory response strobe
    input  logic                            imem_valid_i,
    // prediction on the current response
    input  logic                            predict_valid_i,
    input  logic [frontend_pkg::VLEN-1:0]   predict_target_i,
    // room left in the fetch queue
    input  logic [frontend_pkg::QCNT_W-1:0] free_slots_i,
    output logic                            imem_req_o,
    output logic [frontend_pkg::VLEN-1:0]   imem_addr_o,
    output logic                            resp_valid_o,
    output logic [frontend_pkg::VLEN-1:0]   resp_addr_o,
    output logic                            redirect_o
);
    import frontend_pkg::*;

    logic [VLEN-1:0] npc_d;
    logic [VLEN-1:0] npc_q;
    // low until the first edge after reset release
    logic            run_q;
    // a request went out last cycle, its response lands now
    logic            inflight_q;
    // the response landing now was requested during a redirect
    logic            drop_q;

    // any backend redirect also flushes the frontend
    assign redirect_o = set_debug_pc_i | set_pc_commit_i | ex_valid_i | eret_i
                      | resolve_mispredict_i;

    // the in-flight response still needs a slot of its own
    assign imem_req_o = run_q & (free_slots_i > QCNT_W'(inflight_q));

    // a taken prediction replaces the sequential address in the same cycle
    assign imem_addr_o = predict_valid_i ? predict_target_i : npc_q;

    // stale responses are hidden from scan, predictor and queue
    assign resp_valid_o = imem_valid_i & ~drop_q & ~redirect_o;

    // ------------------------------
    // next PC
    // ------------------------------
    always_comb begin
        // advance only past an address that was actually requested
        npc_d = imem_req_o ? imem_addr_o + VLEN'(4) : imem_addr_o;
        if (set_debug_pc_i) begin
            npc_d = DEBUG_ADDR;
        end else if (set_pc_commit_i) begin
            // restart behind the committing instruction
            npc_d = pc_commit_i + VLEN'(4);
        end else if (ex_valid_i) begin
            npc_d = trap_vector_i;
        end else if (eret_i) begin
            npc_d = epc_i;
        end else if (resolve_mispredict_i) begin
            npc_d = resolve_target_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q      <= BOOT_ADDR;
            run_q      <= 1'b0;
            inflight_q <= 1'b0;
            drop_q     <= 1'b0;
        end else begin
            npc_q      <= npc_d;
            run_q      <= 1'b1;
            inflight_q <= imem_req_o;
            drop_q     <= redirect_o & imem_req_o;
        end
    end

    // address of the outstanding request, pairs with next cycle's data
    always_ff @(posedge clk_i) begin
        if (imem_req_o) begin
            resp_addr_o <= imem_addr_o;
        end
    end

endmodule

//--- source/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // instruction word width
    localparam int unsigned ILEN = 32;

    // ------------------------------
    // major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;

    // link registers, x1 and the alternate x5
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // ------------------------------
    // instruction formats
    // ------------------------------
    // the same 32-bit word viewed as B-, J- and I-format
    typedef union packed {
        // conditional branch, immediate scattered over both ends
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        // jal
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        // jalr and other register-immediate ops
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_u;

endpackage

//--- source/frontend_pkg.sv
package frontend_pkg;

    // ------------------------------
    // address space
    // ------------------------------
    // virtual address width
    localparam int unsigned VLEN = 32;
    // first fetch address once reset is released
    localparam logic [VLEN-1:0] BOOT_ADDR = 32'h0000_0080;
    // debug entry point, taken on set_debug_pc_i
    localparam logic [VLEN-1:0] DEBUG_ADDR = 32'h0000_0800;

    // ------------------------------
    // queue and stack sizing
    // ------------------------------
    // fetch queue entries towards the backend
    localparam int unsigned QUEUE_DEPTH = 4;
    // read/write pointer width, depth is a power of two so pointers wrap
    localparam int unsigned QPTR_W = $clog2(QUEUE_DEPTH);
    // occupancy and free-slot counters, they must hold 0..QUEUE_DEPTH
    localparam int unsigned QCNT_W = $clog2(QUEUE_DEPTH + 1);
    // return-address stack entries
    localparam int unsigned RAS_DEPTH = 2;

    // ------------------------------
    // control-flow kind
    // ------------------------------
    // travels with every fetch entry to the backend
    typedef enum logic [2:0] {
        // plain instruction or a branch predicted not taken
        NO_CF,
        // conditional branch predicted taken
        BRANCH,
        // jal, always taken
        JUMP,
        // register jump that is not a return, never predicted
        JUMP_R,
        // jalr through a link register with rd = x0
        RETURN
    } cf_e;

endpackage
